/* compile.f */
+incdir+tb
src/ctrlPkg.sv
src/instrDecoder.sv
src/condResolver.sv
src/ctrlSequencer.sv
src/mipsControl.sv
tb/mipsControlTb.sv

/* tb/instrPatterns.txt */
# opcode funct overflow equal greater divZero stopDelay length pcSrc wbSrc regDst storeSize trap
# hex except stopDelay and length; pcSrc 7 and wbSrc f mean none; delay 0 on mult/div is random
00 20 0 0 0 0 0  8 7 0 1 0 0  add
00 22 0 0 0 0 0  8 7 0 1 0 0  sub
00 24 0 0 0 0 0  8 7 0 1 0 0  and
00 2a 0 0 0 0 0  7 7 4 1 0 0  slt
08 00 0 0 0 0 0  8 7 0 0 0 0  addi
09 00 0 0 0 0 0  8 7 0 0 0 0  addiu
0a 00 0 0 0 0 0  7 7 4 0 0 0  slti
0f 00 0 0 0 0 0  7 7 6 0 0 0  lui
00 10 0 0 0 0 0  7 7 2 1 0 0  mfhi
00 12 0 0 0 0 0  7 7 3 1 0 0  mflo
04 00 0 1 0 0 0  8 2 f 0 0 0  beq taken
04 00 0 0 0 0 0  8 7 f 0 0 0  beq not taken
05 00 0 0 0 0 0  8 2 f 0 0 0  bne taken
05 00 0 1 0 0 0  8 7 f 0 0 0  bne not taken
06 00 0 0 0 0 0  8 2 f 0 0 0  ble taken
06 00 0 0 1 0 0  8 7 f 0 0 0  ble not taken
07 00 0 0 1 0 0  8 2 f 0 0 0  bgt taken
07 00 0 0 0 0 0  8 7 f 0 0 0  bgt not taken
02 00 0 0 0 0 0  7 3 f 0 0 0  j
00 08 0 0 0 0 0  7 1 f 0 0 0  jr
23 00 0 0 0 0 0 10 7 1 0 0 0  lw
20 00 0 0 0 0 0 10 7 1 0 0 0  lb
2b 00 0 0 0 0 0 11 7 f 0 1 0  sw
29 00 0 0 0 0 0 11 7 f 0 2 0  sh
28 00 0 0 0 0 0 11 7 f 0 3 0  sb
00 18 0 0 0 0 0  8 7 f 0 0 0  mult random delay
00 18 0 0 0 0 3 11 7 f 0 0 0  mult
00 1a 0 0 0 0 0  8 7 f 0 0 0  div random delay
00 1a 0 0 0 0 2 10 7 f 0 0 0  div
00 20 1 0 0 0 0 12 0 f 0 0 1  add overflow trap
08 00 1 0 0 0 0 12 0 f 0 0 1  addi overflow trap
09 00 1 0 0 0 0  8 7 0 0 0 0  addiu ignores overflow
00 3f 0 0 0 0 0 11 0 f 0 0 2  unknown funct
3f 00 0 0 0 0 0 11 0 f 0 0 2  unknown opcode
00 1a 0 0 0 1 3 12 0 f 0 0 3  div by zero

/* tb/ctrlCheckTasks.svh */
`ifndef ctrlCheckTasksSvh
`define ctrlCheckTasksSvh

int lengthErrors = 0;
int pcSrcErrors = 0;
int writebackErrors = 0;
int storeErrors = 0;
int trapErrors = 0;
int otherErrors = 0;    // pulse counts and ctrl word

task automatic checkLength(input string name, input int got, input int exp);
    if (got !== exp) begin
        lengthErrors++;
        $display("[FAIL] %0t ns %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

task automatic checkCount(input string name, input int got, input int exp);
    if (got !== exp) begin
        otherErrors++;
        $display("[FAIL] %0t ns %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

task automatic checkPcSrc(input string name, input ctrlPkg::pcSrcT got,
                          input ctrlPkg::pcSrcT exp);
    if (got !== exp) begin
        pcSrcErrors++;
        $display("[FAIL] %0t ns %s got %s expected %s", $time, name, got.name(), exp.name());
    end
endtask

task automatic checkWriteback(input string name,
                              input ctrlPkg::wbSrcT gotWb, input ctrlPkg::regDstT gotDst,
                              input ctrlPkg::wbSrcT expWb, input ctrlPkg::regDstT expDst);
    if (gotWb !== expWb || gotDst !== expDst) begin
        writebackErrors++;
        $display("[FAIL] %0t ns %s got %s/%s expected %s/%s", $time, name,
                 gotWb.name(), gotDst.name(), expWb.name(), expDst.name());
    end
endtask

task automatic checkStoreSize(input string name, input ctrlPkg::accessSizeT got,
                              input ctrlPkg::accessSizeT exp);
    if (got !== exp) begin
        storeErrors++;
        $display("[FAIL] %0t ns %s got %s expected %s", $time, name, got.name(), exp.name());
    end
endtask

task automatic checkTrap(input string name, input ctrlPkg::trapCauseT got,
                         input ctrlPkg::trapCauseT exp);
    if (got !== exp) begin
        trapErrors++;
        $display("[FAIL] %0t ns %s got %s expected %s", $time, name, got.name(), exp.name());
    end
endtask

task automatic checkCtrlWord(input string name, input ctrlPkg::ctrlWordT got,
                             input ctrlPkg::ctrlWordT exp);
    if (got !== exp) begin
        otherErrors++;
        $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
    end
endtask

function automatic int totalErrors();
    return lengthErrors + pcSrcErrors + writebackErrors + storeErrors + trapErrors
           + otherErrors;
endfunction

`endif

/* tb/mipsControlTb.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsControlTb;

    localparam int memWaitCycles = 2;
    localparam int maxPatterns = 64;

    logic              clk;
    logic              reset;
    ctrlPkg::opcodeT   opcode;
    ctrlPkg::functT    funct;
    ctrlPkg::cpuFlagsT flags;
    ctrlPkg::ctrlWordT ctrl;

    // one entry per pattern line
    logic [5:0] patOpcode [maxPatterns];
    logic [5:0] patFunct [maxPatterns];
    logic [3:0] patFlags [maxPatterns];    // overflow, equal, greater, divZero
    int         patDelay [maxPatterns];
    int         expLen [maxPatterns];
    int         expPc [maxPatterns];
    int         expWb [maxPatterns];
    int         expDst [maxPatterns];
    int         expStore [maxPatterns];
    int         expTrap [maxPatterns];
    int         numPatterns = 0;

    // per-instruction monitor state
    int                    instrLen;
    int                    pcWrites;
    int                    regWrites;
    int                    memWrites;
    int                    hiLoWrites;
    int                    abWrites;
    ctrlPkg::pcSrcT        firstPcSrc;
    ctrlPkg::wbSrcT        seenWb;
    ctrlPkg::regDstT       seenDst;
    ctrlPkg::accessSizeT   seenStore;
    ctrlPkg::trapCauseT    seenCause;
    ctrlPkg::ctrlWordT     idleExp;    // no strobes, each select at its first code

    logic        unitBusy;
    logic        unitIsDiv;
    int          stopCount;
    int          curDelay;
    int          idx;
    logic        running;
    int          cycleCount = 0;
    int          cycleLimit = 0;

    mipsControl #(
        .memWaitCycles (memWaitCycles)
    ) mipsControl_i (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode),
        .funct  (funct),
        .flags  (flags),
        .ctrl   (ctrl)
    );

    `include "ctrlCheckTasks.svh"

    function automatic logic isUnitOp(input logic [5:0] op, input logic [5:0] fn);
        return op == ctrlPkg::opRType && (fn == ctrlPkg::fnMult || fn == ctrlPkg::fnDiv);
    endfunction

    function automatic ctrlPkg::trapCauseT causeFromVector(input ctrlPkg::iordSelT sel);
        case (sel)
            ctrlPkg::iordOverflowVec: return ctrlPkg::trapOverflow;
            ctrlPkg::iordIllegalVec:  return ctrlPkg::trapIllegal;
            ctrlPkg::iordDivZeroVec:  return ctrlPkg::trapDivZero;
            default:                  return ctrlPkg::trapNone;
        endcase
    endfunction

    task automatic loadPatterns();
        int    fd;
        int    fields;
        int    col [13];
        string line;
        fd = $fopen("tb/instrPatterns.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/instrPatterns.txt");
            otherErrors++;
        end else begin
            while (!$feof(fd) && numPatterns < maxPatterns) begin
                line = "";
                fields = $fgets(line, fd);
                if (line.len() > 1 && line[0] != "#") begin
                    fields = $sscanf(line, "%h %h %h %h %h %h %d %d %h %h %h %h %h",
                                     col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                                     col[7], col[8], col[9], col[10], col[11], col[12]);
                    if (fields != 13) begin
                        $display("malformed pattern line: %s", line);
                        otherErrors++;
                    end else begin
                        patOpcode[numPatterns] = col[0][5:0];
                        patFunct[numPatterns] = col[1][5:0];
                        patFlags[numPatterns] = {col[2][0], col[3][0], col[4][0], col[5][0]};
                        patDelay[numPatterns] = col[6];
                        expLen[numPatterns] = col[7];
                        expPc[numPatterns] = col[8];
                        expWb[numPatterns] = col[9];
                        expDst[numPatterns] = col[10];
                        expStore[numPatterns] = col[11];
                        expTrap[numPatterns] = col[12];
                        // random stop delay adds to the base length
                        if (col[6] == 0 && isUnitOp(col[0][5:0], col[1][5:0])) begin
                            patDelay[numPatterns] = 2 + $urandom % 5;
                            expLen[numPatterns] += patDelay[numPatterns];
                        end
                        numPatterns++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic applyPattern(input int i);
        opcode = patOpcode[i];
        funct = patFunct[i];
        flags = '0;
        {flags.overflow, flags.equal, flags.greater, flags.divZero} = patFlags[i];
        curDelay = patDelay[i];
        unitBusy = 1'b0;
        stopCount = 0;
        instrLen = 0;
        pcWrites = 0;
        regWrites = 0;
        memWrites = 0;
        hiLoWrites = 0;
        abWrites = 0;
        seenCause = ctrlPkg::trapNone;
    endtask

    task automatic observeCycle();
        instrLen++;
        if (ctrl.pcWrite) begin
            if (pcWrites == 0)
                firstPcSrc = ctrl.pcSrc;   // fetch pcWrite always comes last
            pcWrites++;
        end
        if (ctrl.regWrite) begin
            regWrites++;
            seenWb = ctrl.wbSrc;
            seenDst = ctrl.regDst;
        end
        if (ctrl.memWrite) begin
            memWrites++;
            seenStore = ctrl.storeSize;
        end
        if (ctrl.hiLoWrite)
            hiLoWrites++;
        if (ctrl.abWrite)
            abWrites++;
        if (causeFromVector(ctrl.iordSel) != ctrlPkg::trapNone)
            seenCause = causeFromVector(ctrl.iordSel);
    endtask

    // stop flag rises on the delay-th cycle counted from the start pulse
    task automatic driveUnitStop();
        if (ctrl.multStart || ctrl.divStart) begin
            unitBusy = 1'b1;
            unitIsDiv = ctrl.divStart;
            stopCount = 1;
        end else if (unitBusy) begin
            stopCount++;
        end
        flags.multStop = unitBusy && !unitIsDiv && stopCount >= curDelay;
        flags.divStop = unitBusy && unitIsDiv && stopCount >= curDelay;
    endtask

    task automatic checkInstruction(input int i);
        string tag;
        tag = $sformatf("pattern %0d", i);
        checkLength({tag, " length"}, instrLen, expLen[i]);
        checkCount({tag, " abWrite pulses"}, abWrites, 1);
        if (expPc[i] == 7) begin
            checkCount({tag, " pcWrite pulses"}, pcWrites, 1);
        end else begin
            checkCount({tag, " pcWrite pulses"}, pcWrites, 2);
            checkPcSrc({tag, " pcSrc"}, firstPcSrc, ctrlPkg::pcSrcT'(expPc[i]));
        end
        if (expWb[i] == 'hf) begin
            checkCount({tag, " regWrite pulses"}, regWrites, 0);
        end else begin
            checkCount({tag, " regWrite pulses"}, regWrites, 1);
            checkWriteback({tag, " wbSrc/regDst"}, seenWb, seenDst,
                           ctrlPkg::wbSrcT'(expWb[i]), ctrlPkg::regDstT'(expDst[i]));
        end
        if (expStore[i] == 0) begin
            checkCount({tag, " memWrite pulses"}, memWrites, 0);
        end else begin
            checkCount({tag, " memWrite pulses"}, memWrites, 1);
            checkStoreSize({tag, " storeSize"}, seenStore,
                           ctrlPkg::accessSizeT'(expStore[i]));
        end
        checkCount({tag, " hiLoWrite pulses"}, hiLoWrites,
                   (isUnitOp(patOpcode[i], patFunct[i]) && expTrap[i] == 0) ? 1 : 0);
        checkTrap({tag, " trap cause"}, seenCause, ctrlPkg::trapCauseT'(expTrap[i]));
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("run timed out after %0d cycles", cycleCount);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        opcode = '0;
        funct = '0;
        flags = '0;
        unitBusy = 1'b0;
        unitIsDiv = 1'b0;
        curDelay = 0;
        idleExp = '0;
        void'($urandom(32'ha88f9494));
        loadPatterns();
        if (numPatterns == 0) begin
            $display("no instruction patterns were read");
            otherErrors++;
        end
        cycleLimit = 50;
        for (int i = 0; i < numPatterns; i++)
            cycleLimit += expLen[i];

        repeat (4) @(negedge clk);
        checkCtrlWord("ctrl after reset", ctrl, idleExp);
        reset = 1'b0;

        idx = -1;
        running = (numPatterns > 0);
        while (running) begin
            @(negedge clk);
            if (idx >= 0)
                observeCycle();
            if (ctrl.irWrite) begin
                if (idx >= 0)
                    checkInstruction(idx);
                idx++;
                if (idx >= numPatterns)
                    running = 1'b0;
                else
                    applyPattern(idx);
            end
            driveUnitStop();
        end

        $display("errors: length %0d, pcSrc %0d, writeback %0d, store %0d, trap %0d, other %0d",
                 lengthErrors, pcSrcErrors, writebackErrors, storeErrors, trapErrors,
                 otherErrors);
        if (totalErrors() == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/mipsControl.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsControl #(
    parameter int memWaitCycles = 2
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire ctrlPkg::opcodeT   opcode,
    input  wire ctrlPkg::functT    funct,
    input  wire ctrlPkg::cpuFlagsT flags,
    output ctrlPkg::ctrlWordT      ctrl
);

    ctrlPkg::decodedOpT decoded;
    logic               branchTaken;
    logic               overflowTrap;

    instrDecoder instrDecoder_i (
        .opcode  (opcode),
        .funct   (funct),
        .decoded (decoded)
    );

    // runs alongside the decoder output, no extra cycle
    condResolver condResolver_i (
        .decoded      (decoded),
        .flags        (flags),
        .branchTaken  (branchTaken),
        .overflowTrap (overflowTrap)
    );

    ctrlSequencer #(
        .memWaitCycles (memWaitCycles)
    ) ctrlSequencer_i (
        .clk          (clk),
        .reset        (reset),
        .decoded      (decoded),
        .flags        (flags),
        .branchTaken  (branchTaken),
        .overflowTrap (overflowTrap),
        .ctrl         (ctrl)
    );

endmodule

`default_nettype wire

/* src/ctrlSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrlSequencer #(
    parameter int memWaitCycles = 2
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire ctrlPkg::decodedOpT decoded,
    input  wire ctrlPkg::cpuFlagsT  flags,
    input  wire                     branchTaken,
    input  wire                     overflowTrap,
    output ctrlPkg::ctrlWordT       ctrl
);

    localparam int cntW = $clog2(memWaitCycles + 1);
    localparam logic [cntW-1:0] waitLoad = cntW'(memWaitCycles - 1);

    typedef enum logic [4:0] {
        stFetch1, stFetch2, stFetch3, stDecode1, stDecode2, stExecute,
        stAluCheck, stBranch, stStoreAddr, stMemWait, stLoadWb, stStoreWrite,
        stUnitWait, stHiLo, stTrapVec, stTrapPc, stClosing
    } stateT;

    stateT              state;
    stateT              stateNext;
    logic [cntW-1:0]    waitCnt;
    logic [cntW-1:0]    waitCntNext;
    ctrlPkg::trapCauseT cause;
    ctrlPkg::trapCauseT causeNext;
    ctrlPkg::trapCauseT trapCause;
    ctrlPkg::ctrlWordT  ctrlNext;
    logic               trapReq;
    logic               unitStop;

    assign unitStop = decoded.hiLoSel ? flags.divStop : flags.multStop;

    always_comb begin
        stateNext = state;
        waitCntNext = waitCnt;
        causeNext = cause;
        trapReq = 1'b0;
        trapCause = ctrlPkg::trapNone;
        // selects hold, strobes last one cycle
        ctrlNext = ctrl;
        ctrlNext.memWrite = 1'b0;
        ctrlNext.pcWrite = 1'b0;
        ctrlNext.irWrite = 1'b0;
        ctrlNext.regWrite = 1'b0;
        ctrlNext.abWrite = 1'b0;
        ctrlNext.hiLoWrite = 1'b0;
        ctrlNext.aluOutWrite = 1'b0;
        ctrlNext.epcWrite = 1'b0;
        ctrlNext.multStart = 1'b0;
        ctrlNext.divStart = 1'b0;

        case (state)
            stFetch1: begin
                ctrlNext = ctrlPkg::ctrlIdle;
                ctrlNext.srcBSel = ctrlPkg::srcBFour;
                ctrlNext.aluOp = ctrlPkg::aluAdd;   // pc + 4
                stateNext = stFetch2;
            end
            stFetch2: begin
                ctrlNext.pcWrite = 1'b1;
                ctrlNext.pcSrc = ctrlPkg::pcAluResult;
                stateNext = stFetch3;
            end
            stFetch3: begin
                ctrlNext.irWrite = 1'b1;
                stateNext = stDecode1;
            end
            stDecode1: begin
                // branch target computed early into aluOut
                ctrlNext.srcBSel = ctrlPkg::srcBBranchOff;
                ctrlNext.aluOutWrite = 1'b1;
                stateNext = stDecode2;
            end
            stDecode2: begin
                ctrlNext.abWrite = 1'b1;
                stateNext = stExecute;
            end
            stExecute: begin
                ctrlNext.srcASel = ctrlPkg::srcARegA;
                ctrlNext.srcBSel = decoded.srcBSel;
                ctrlNext.aluOp = decoded.aluOp;
                ctrlNext.regDst = decoded.regDst;
                ctrlNext.wbSrc = decoded.wbSrc;
                stateNext = stClosing;
                case (decoded.instrClass)
                    ctrlPkg::clsAluReg, ctrlPkg::clsAluImm: begin
                        ctrlNext.aluOutWrite = 1'b1;
                        stateNext = stAluCheck;
                    end
                    ctrlPkg::clsSetLess, ctrlPkg::clsLoadUpper, ctrlPkg::clsMoveHiLo: begin
                        ctrlNext.regWrite = 1'b1;
                    end
                    ctrlPkg::clsBranch: stateNext = stBranch;
                    ctrlPkg::clsJump: begin
                        ctrlNext.pcWrite = 1'b1;
                        ctrlNext.pcSrc = ctrlPkg::pcJumpTarget;
                    end
                    ctrlPkg::clsJumpReg: begin
                        ctrlNext.pcWrite = 1'b1;
                        ctrlNext.pcSrc = ctrlPkg::pcAluResult;   // rs passed through
                    end
                    ctrlPkg::clsLoad: begin
                        ctrlNext.iordSel = ctrlPkg::iordAluResult;
                        waitCntNext = waitLoad;
                        stateNext = stMemWait;
                    end
                    ctrlPkg::clsStore: begin
                        ctrlNext.aluOutWrite = 1'b1;
                        stateNext = stStoreAddr;
                    end
                    ctrlPkg::clsMultiply: begin
                        ctrlNext.multStart = 1'b1;
                        stateNext = stUnitWait;
                    end
                    ctrlPkg::clsDivide: begin
                        ctrlNext.divStart = 1'b1;
                        stateNext = stUnitWait;
                    end
                    default: begin
                        trapReq = 1'b1;
                        trapCause = ctrlPkg::trapIllegal;
                    end
                endcase
            end
            stAluCheck: begin
                if (overflowTrap) begin
                    trapReq = 1'b1;
                    trapCause = ctrlPkg::trapOverflow;
                end else begin
                    ctrlNext.regWrite = 1'b1;
                    ctrlNext.wbSrc = ctrlPkg::wbAluOut;
                    stateNext = stClosing;
                end
            end
            stBranch: begin
                if (branchTaken) begin
                    ctrlNext.pcWrite = 1'b1;
                    ctrlNext.pcSrc = ctrlPkg::pcBranchTarget;
                end
                stateNext = stClosing;
            end
            stStoreAddr: begin
                ctrlNext.iordSel = ctrlPkg::iordAluOut;
                waitCntNext = waitLoad;
                stateNext = stMemWait;
            end
            stMemWait: begin
                if (waitCnt != '0) begin
                    waitCntNext = waitCnt - 1'b1;
                end else if (cause != ctrlPkg::trapNone) begin
                    stateNext = stTrapPc;
                end else if (decoded.instrClass == ctrlPkg::clsLoad) begin
                    stateNext = stLoadWb;
                end else begin
                    stateNext = stStoreWrite;
                end
            end
            stLoadWb: begin
                ctrlNext.regWrite = 1'b1;
                ctrlNext.loadSize = decoded.accessSize;
                stateNext = stClosing;
            end
            stStoreWrite: begin
                ctrlNext.memWrite = 1'b1;
                ctrlNext.storeSize = decoded.accessSize;
                stateNext = stClosing;
            end
            stUnitWait: begin
                if (decoded.instrClass == ctrlPkg::clsDivide && flags.divZero) begin
                    trapReq = 1'b1;
                    trapCause = ctrlPkg::trapDivZero;
                end else if (unitStop) begin
                    stateNext = stHiLo;
                end
            end
            stHiLo: begin
                ctrlNext.hiLoWrite = 1'b1;
                ctrlNext.hiLoSel = decoded.hiLoSel;
                stateNext = stClosing;
            end
            stTrapVec: begin
                case (cause)
                    ctrlPkg::trapOverflow: ctrlNext.iordSel = ctrlPkg::iordOverflowVec;
                    ctrlPkg::trapDivZero:  ctrlNext.iordSel = ctrlPkg::iordDivZeroVec;
                    default:               ctrlNext.iordSel = ctrlPkg::iordIllegalVec;
                endcase
                ctrlNext.loadSize = ctrlPkg::sizeByte;   // handler address is one byte
                waitCntNext = waitLoad;
                stateNext = stMemWait;
            end
            stTrapPc: begin
                ctrlNext.pcWrite = 1'b1;
                ctrlNext.pcSrc = ctrlPkg::pcTrapVector;
                stateNext = stClosing;
            end
            stClosing: begin
                ctrlNext = ctrlPkg::ctrlIdle;
                causeNext = ctrlPkg::trapNone;
                stateNext = stFetch1;
            end
            default: begin
                ctrlNext = ctrlPkg::ctrlIdle;
                stateNext = stFetch1;
            end
        endcase

        if (trapReq) begin
            // epc gets pc - 4
            ctrlNext.srcASel = ctrlPkg::srcAPc;
            ctrlNext.srcBSel = ctrlPkg::srcBFour;
            ctrlNext.aluOp = ctrlPkg::aluSub;
            ctrlNext.epcWrite = 1'b1;
            causeNext = trapCause;
            stateNext = stTrapVec;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stFetch1;
            waitCnt <= '0;
            cause <= ctrlPkg::trapNone;
            ctrl <= ctrlPkg::ctrlIdle;
        end else begin
            state <= stateNext;
            waitCnt <= waitCntNext;
            cause <= causeNext;
            ctrl <= ctrlNext;
        end
    end

endmodule

`default_nettype wire

/* src/condResolver.sv */
`timescale 1ns/1ps
`default_nettype none

module condResolver (
    input  wire ctrlPkg::decodedOpT decoded,
    input  wire ctrlPkg::cpuFlagsT  flags,
    output logic                    branchTaken,
    output logic                    overflowTrap
);

    always_comb begin
        case (decoded.branchKind)
            ctrlPkg::brEqual:     branchTaken = flags.equal;
            ctrlPkg::brNotEqual:  branchTaken = !flags.equal;
            ctrlPkg::brLessEqual: branchTaken = !flags.greater;
            default:              branchTaken = flags.greater;   // bgt
        endcase
    end

    // addiu and and never trap even if the ALU flags it
    assign overflowTrap = flags.overflow && decoded.overflowCheck;

endmodule

`default_nettype wire

/* src/instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  wire ctrlPkg::opcodeT    opcode,
    input  wire ctrlPkg::functT     funct,
    output ctrlPkg::decodedOpT      decoded
);

    // low two opcode bits give the access size for loads and stores
    function automatic ctrlPkg::accessSizeT sizeOf(input ctrlPkg::opcodeT op);
        case (op[1:0])
            2'd0:    return ctrlPkg::sizeByte;
            2'd1:    return ctrlPkg::sizeHalf;
            default: return ctrlPkg::sizeWord;
        endcase
    endfunction

    always_comb begin
        decoded = ctrlPkg::illegalOp;
        case (opcode)
            ctrlPkg::opRType: begin
                decoded.regDst = ctrlPkg::dstRd;
                case (funct)
                    ctrlPkg::fnAdd, ctrlPkg::fnSub: begin
                        decoded.instrClass = ctrlPkg::clsAluReg;
                        decoded.aluOp = (funct == ctrlPkg::fnAdd) ? ctrlPkg::aluAdd : ctrlPkg::aluSub;
                        decoded.overflowCheck = 1'b1;
                    end
                    ctrlPkg::fnAnd: begin
                        decoded.instrClass = ctrlPkg::clsAluReg;
                        decoded.aluOp = ctrlPkg::aluAnd;
                    end
                    ctrlPkg::fnSlt: begin
                        decoded.instrClass = ctrlPkg::clsSetLess;
                        decoded.aluOp = ctrlPkg::aluCompare;
                        decoded.wbSrc = ctrlPkg::wbCompare;
                    end
                    ctrlPkg::fnMfhi, ctrlPkg::fnMflo: begin
                        decoded.instrClass = ctrlPkg::clsMoveHiLo;
                        decoded.wbSrc = (funct == ctrlPkg::fnMfhi) ? ctrlPkg::wbHi : ctrlPkg::wbLo;
                    end
                    ctrlPkg::fnJr:   decoded.instrClass = ctrlPkg::clsJumpReg;
                    ctrlPkg::fnMult: decoded.instrClass = ctrlPkg::clsMultiply;
                    ctrlPkg::fnDiv: begin
                        decoded.instrClass = ctrlPkg::clsDivide;
                        decoded.hiLoSel = 1'b1;
                    end
                    default: decoded.instrClass = ctrlPkg::clsIllegal;   // unknown funct traps
                endcase
            end
            ctrlPkg::opAddi, ctrlPkg::opAddiu: begin
                decoded.instrClass = ctrlPkg::clsAluImm;
                decoded.aluOp = ctrlPkg::aluAdd;
                decoded.srcBSel = ctrlPkg::srcBImm;
                decoded.overflowCheck = (opcode == ctrlPkg::opAddi);
            end
            ctrlPkg::opSlti: begin
                decoded.instrClass = ctrlPkg::clsSetLess;
                decoded.aluOp = ctrlPkg::aluCompare;
                decoded.srcBSel = ctrlPkg::srcBImm;
                decoded.wbSrc = ctrlPkg::wbCompare;
            end
            ctrlPkg::opLui: begin
                decoded.instrClass = ctrlPkg::clsLoadUpper;
                decoded.wbSrc = ctrlPkg::wbUpperImm;
            end
            ctrlPkg::opBeq, ctrlPkg::opBne, ctrlPkg::opBle, ctrlPkg::opBgt: begin
                decoded.instrClass = ctrlPkg::clsBranch;
                decoded.aluOp = ctrlPkg::aluCompare;
                decoded.branchKind = ctrlPkg::branchKindT'(opcode[1:0]);   // beq..bgt in order
            end
            ctrlPkg::opJ: decoded.instrClass = ctrlPkg::clsJump;
            ctrlPkg::opLw, ctrlPkg::opLh, ctrlPkg::opLb: begin
                decoded.instrClass = ctrlPkg::clsLoad;
                decoded.aluOp = ctrlPkg::aluAdd;
                decoded.srcBSel = ctrlPkg::srcBImm;
                decoded.wbSrc = ctrlPkg::wbMemory;
                decoded.accessSize = sizeOf(opcode);
            end
            ctrlPkg::opSw, ctrlPkg::opSh, ctrlPkg::opSb: begin
                decoded.instrClass = ctrlPkg::clsStore;
                decoded.aluOp = ctrlPkg::aluAdd;
                decoded.srcBSel = ctrlPkg::srcBImm;
                decoded.accessSize = sizeOf(opcode);
            end
            default: decoded.instrClass = ctrlPkg::clsIllegal;
        endcase
    end

endmodule

`default_nettype wire

/* src/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;

    localparam opcodeT opRType = 6'h00;
    localparam opcodeT opJ     = 6'h02;
    localparam opcodeT opBeq   = 6'h04;
    localparam opcodeT opBne   = 6'h05;
    localparam opcodeT opBle   = 6'h06;
    localparam opcodeT opBgt   = 6'h07;
    localparam opcodeT opAddi  = 6'h08;
    localparam opcodeT opAddiu = 6'h09;
    localparam opcodeT opSlti  = 6'h0a;
    localparam opcodeT opLui   = 6'h0f;
    localparam opcodeT opLb    = 6'h20;
    localparam opcodeT opLh    = 6'h21;
    localparam opcodeT opLw    = 6'h23;
    localparam opcodeT opSb    = 6'h28;
    localparam opcodeT opSh    = 6'h29;
    localparam opcodeT opSw    = 6'h2b;

    localparam functT fnJr   = 6'h08;
    localparam functT fnMfhi = 6'h10;
    localparam functT fnMflo = 6'h12;
    localparam functT fnMult = 6'h18;
    localparam functT fnDiv  = 6'h1a;
    localparam functT fnAdd  = 6'h20;
    localparam functT fnSub  = 6'h22;
    localparam functT fnAnd  = 6'h24;
    localparam functT fnSlt  = 6'h2a;

    typedef enum logic [3:0] {
        clsAluReg, clsAluImm, clsSetLess, clsLoadUpper, clsMoveHiLo,
        clsBranch, clsJump, clsJumpReg, clsLoad, clsStore,
        clsMultiply, clsDivide, clsIllegal
    } instrClassT;

    typedef enum logic [2:0] {
        aluPass = 3'd0, aluAdd = 3'd1, aluSub = 3'd2, aluAnd = 3'd3, aluCompare = 3'd7
    } aluOpT;

    typedef enum logic [1:0] {srcAPc = 2'd0, srcARegA = 2'd1} srcASelT;
    typedef enum logic [1:0] {srcBRegB, srcBFour, srcBImm, srcBBranchOff} srcBSelT;
    typedef enum logic [2:0] {dstRt = 3'd0, dstRd = 3'd1} regDstT;

    typedef enum logic [3:0] {
        wbAluOut = 4'd0, wbMemory = 4'd1, wbHi = 4'd2, wbLo = 4'd3,
        wbCompare = 4'd4, wbUpperImm = 4'd6
    } wbSrcT;

    typedef enum logic [2:0] {pcTrapVector, pcAluResult, pcBranchTarget, pcJumpTarget} pcSrcT;

    // vector slots follow the datapath mux order
    typedef enum logic [2:0] {
        iordPc = 3'd0, iordAluResult = 3'd1, iordAluOut = 3'd2,
        iordIllegalVec = 3'd3, iordOverflowVec = 3'd4, iordDivZeroVec = 3'd5
    } iordSelT;

    typedef enum logic [1:0] {sizeNone, sizeWord, sizeHalf, sizeByte} accessSizeT;
    typedef enum logic [1:0] {brEqual, brNotEqual, brLessEqual, brGreater} branchKindT;
    typedef enum logic [1:0] {trapNone, trapOverflow, trapIllegal, trapDivZero} trapCauseT;

    typedef struct packed {
        logic overflow;
        logic equal;
        logic greater;
        logic multStop;
        logic divStop;
        logic divZero;
    } cpuFlagsT;

    typedef struct packed {
        instrClassT instrClass;
        aluOpT      aluOp;
        srcBSelT    srcBSel;
        regDstT     regDst;
        wbSrcT      wbSrc;
        accessSizeT accessSize;
        branchKindT branchKind;
        logic       overflowCheck;
        logic       hiLoSel;    // 0 mult, 1 div
    } decodedOpT;

    typedef struct packed {
        logic       memWrite;
        logic       pcWrite;
        logic       irWrite;
        logic       regWrite;
        logic       abWrite;
        logic       hiLoWrite;
        logic       aluOutWrite;
        logic       epcWrite;
        logic       multStart;
        logic       divStart;
        aluOpT      aluOp;
        srcASelT    srcASel;
        srcBSelT    srcBSel;
        regDstT     regDst;
        wbSrcT      wbSrc;
        pcSrcT      pcSrc;
        iordSelT    iordSel;
        logic       hiLoSel;
        accessSizeT loadSize;
        accessSizeT storeSize;
    } ctrlWordT;

    localparam decodedOpT illegalOp = '{
        instrClass: clsIllegal, aluOp: aluPass, srcBSel: srcBRegB, regDst: dstRt,
        wbSrc: wbAluOut, accessSize: sizeNone, branchKind: brEqual,
        overflowCheck: 1'b0, hiLoSel: 1'b0
    };

    localparam ctrlWordT ctrlIdle = '{
        memWrite: 1'b0, pcWrite: 1'b0, irWrite: 1'b0, regWrite: 1'b0,
        abWrite: 1'b0, hiLoWrite: 1'b0, aluOutWrite: 1'b0, epcWrite: 1'b0,
        multStart: 1'b0, divStart: 1'b0,
        aluOp: aluPass, srcASel: srcAPc, srcBSel: srcBRegB, regDst: dstRt,
        wbSrc: wbAluOut, pcSrc: pcTrapVector, iordSel: iordPc, hiLoSel: 1'b0,
        loadSize: sizeNone, storeSize: sizeNone
    };

endpackage

`default_nettype wire
